// ==== include/bp_config.svh ====
/*
 * Sizing constants for the fetch-side branch prediction subsystem.
 * Included by the package and by every RTL block that needs a width.
 */
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

`define BP_PC_W        16       // Fetch address width
`define BP_IDX_W       3        // Table index, taken from pc[3:1]
`define BP_TAG_W       12       // Tag, taken from pc[15:4]
`define BP_FIFO_DEPTH  4        // Max in-flight prediction records
`define BP_RESET_PC    16'h0000 // First fetch address after reset

`endif

// ==== verilog/bp_pkg.sv ====
/*
 * Shared types for the branch prediction subsystem: the BHT and BTB
 * entries and the per-slot fetch record kept until resolution.
 * Blocks refer to these by bp_pkg:: scoped names.
 */
`include "bp_config.svh"

package bp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Table entries
  ////////////////////////////////////////////////////////////////////////////
  // Counter encoding: 0 strong NT, 1 weak NT, 2 weak T, 3 strong T
  typedef struct packed {
    logic                 valid;   // Entry holds a real branch
    logic [`BP_TAG_W-1:0] tag;     // pc[15:4] of the owner
    logic [1:0]           counter; // 2-bit saturating history
  } bht_entry_t;

  typedef struct packed {
    logic                 valid;   // Target has been learned
    logic [`BP_TAG_W-1:0] tag;     // pc[15:4] of the owner
    logic [`BP_PC_W-1:0]  target;  // Last taken target
  } btb_entry_t;

  ////////////////////////////////////////////////////////////////////////////
  // In-flight record
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [`BP_PC_W-1:0] pc;          // Fetched slot address
    logic [1:0]          counter;     // Counter seen at fetch time
    logic                hit;         // BHT tag matched at fetch
    logic                pred_taken;  // Direction guess
    logic [`BP_PC_W-1:0] pred_target; // Target guess, pc+2 on BTB miss
  } fetch_rec_t;

endpackage

// ==== verilog/fetch_pc_gen.sv ====
/*
 * Fetch PC register. Steps once per issued slot along the predicted
 * path and jumps to the resolver's redirect PC on a mispredict.
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module fetch_pc_gen (
  input  logic                clk,
  input  logic                rst,          // Sync, active high
  input  logic                issue,        // Slot accepted this cycle
  input  logic                pred_taken,   // Predictor direction for fetch_pc
  input  logic [`BP_PC_W-1:0] pred_target,  // Predictor target for fetch_pc
  input  logic                redirect,     // Mispredict from resolver
  input  logic [`BP_PC_W-1:0] redirect_pc,  // Corrected fetch address
  output logic [`BP_PC_W-1:0] fetch_pc
);

  localparam logic [`BP_PC_W-1:0] PC_STEP = `BP_PC_W'(2); // 2-byte instructions

  logic [`BP_PC_W-1:0] pc_q;    // Current fetch address
  logic [`BP_PC_W-1:0] pc_seq;  // Fall-through address
  logic [`BP_PC_W-1:0] pc_next; // Address for the next cycle

  assign pc_seq = pc_q + PC_STEP;

  ////////////////////////////////////////////////////////////////////////////
  // Next PC select
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    pc_next = pc_q;                // Stall holds the PC
    if (redirect) begin
      pc_next = redirect_pc;       // Mispredict wins over everything
    end else if (issue) begin
      if (pred_taken) begin
        pc_next = pred_target;     // Follow predicted branch
      end else begin
        pc_next = pc_seq;          // Sequential slot
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `BP_RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign fetch_pc = pc_q;

endmodule

// ==== verilog/branch_predictor.sv ====
/*
 * Direct-mapped BHT and BTB, eight entries each, indexed by pc[3:1]
 * and tagged by pc[15:4]. Lookup is combinational on rd_pc; the
 * resolver writes both tables through the wr_* port at the clock edge.
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_predictor (
  input  logic                clk,
  input  logic                rst,          // Clears valid bits only
  input  logic [`BP_PC_W-1:0] rd_pc,        // Lookup address (fetch PC)
  input  logic                bht_wen,      // Write counter entry
  input  logic                btb_wen,      // Write target entry
  input  logic [`BP_PC_W-1:0] wr_pc,        // Address of resolved branch
  input  logic [1:0]          wr_counter,   // New counter value
  input  logic [`BP_PC_W-1:0] wr_target,    // New target value
  output logic                hit,          // BHT tag match
  output logic [1:0]          counter,      // Raw counter at rd index
  output logic                pred_taken,
  output logic [`BP_PC_W-1:0] pred_target
);

  localparam int unsigned ENTRIES = 1 << `BP_IDX_W;
  localparam logic [`BP_PC_W-1:0] PC_STEP = `BP_PC_W'(2);

  bp_pkg::bht_entry_t bht [ENTRIES]; // Branch history table
  bp_pkg::btb_entry_t btb [ENTRIES]; // Branch target buffer

  logic [`BP_IDX_W-1:0] rd_idx;
  logic [`BP_TAG_W-1:0] rd_tag;
  logic [`BP_IDX_W-1:0] wr_idx;
  logic [`BP_TAG_W-1:0] wr_tag;
  logic                 btb_hit;

  // Split addresses; bit 0 is always zero for 2-byte slots
  assign rd_idx = rd_pc[`BP_IDX_W:1];
  assign rd_tag = rd_pc[`BP_PC_W-1:`BP_IDX_W+1];
  assign wr_idx = wr_pc[`BP_IDX_W:1];
  assign wr_tag = wr_pc[`BP_PC_W-1:`BP_IDX_W+1];

  ////////////////////////////////////////////////////////////////////////////
  // Table writes
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        bht[i].valid <= 1'b0;       // Payload left as is
        btb[i].valid <= 1'b0;
      end
    end else begin
      if (bht_wen) begin
        bht[wr_idx] <= '{valid: 1'b1, tag: wr_tag, counter: wr_counter};
      end
      if (btb_wen) begin
        btb[wr_idx] <= '{valid: 1'b1, tag: wr_tag, target: wr_target};
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////
  assign hit     = bht[rd_idx].valid && (bht[rd_idx].tag == rd_tag);
  assign btb_hit = btb[rd_idx].valid && (btb[rd_idx].tag == rd_tag);
  assign counter = bht[rd_idx].counter;

  // Only a matching entry in a taken state predicts taken
  assign pred_taken = hit & counter[1];

  // No learned target means fall through
  assign pred_target = btb_hit ? btb[rd_idx].target : rd_pc + PC_STEP;

endmodule

// ==== verilog/resolve_fifo.sv ====
/*
 * Circular buffer of fetch records awaiting their execute outcome.
 * Head is shown combinationally; flush drops every entry at the edge.
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module resolve_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,      // Store push_rec at tail
  input  bp_pkg::fetch_rec_t     push_rec,
  input  logic                   pop,       // Drop head entry
  input  logic                   flush,     // Empty the buffer
  output bp_pkg::fetch_rec_t     head_rec,  // Oldest record
  output logic                   full,
  output logic                   empty
);

  localparam int unsigned PTR_W = $clog2(`BP_FIFO_DEPTH);

  bp_pkg::fetch_rec_t mem [`BP_FIFO_DEPTH]; // Record storage, no reset

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;   // One extra bit to reach DEPTH
  logic             do_push;
  logic             do_pop;

  assign full    = (count == (PTR_W+1)'(`BP_FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push & ~full;   // Ignore push into a full buffer
  assign do_pop  = pop & ~empty;   // Ignore pop from an empty buffer

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_rec;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1; // Wraps at power-of-two depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // None, or both at once
      endcase
    end
  end

  assign head_rec = mem[rd_ptr];

endmodule

// ==== verilog/branch_resolver.sv ====
/*
 * Turns an execute outcome plus the oldest fetch record into table
 * writes and, on a wrong guess, a redirect. Purely combinational; all
 * outputs are qualified by resolve_fire.
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_resolver (
  input  logic                resolve_fire,  // Outcome accepted this cycle
  input  bp_pkg::fetch_rec_t  head_rec,      // Record of resolving slot
  input  logic                actual_taken,
  input  logic [`BP_PC_W-1:0] actual_target,
  output logic                bht_wen,
  output logic                btb_wen,
  output logic [`BP_PC_W-1:0] wr_pc,
  output logic [1:0]          wr_counter,
  output logic [`BP_PC_W-1:0] wr_target,
  output logic                mispredict,
  output logic [`BP_PC_W-1:0] redirect_pc
);

  localparam logic [`BP_PC_W-1:0] PC_STEP = `BP_PC_W'(2);

  logic dir_wrong; // Direction guess was wrong
  logic tgt_wrong; // Taken both ways but wrong target

  ////////////////////////////////////////////////////////////////////////////
  // Counter update, based on the counter seen at fetch time
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (!head_rec.hit) begin
      wr_counter = 2'd0;                        // New owner starts strong NT
    end else if (actual_taken) begin
      if (head_rec.counter == 2'd3) begin
        wr_counter = 2'd3;                      // Saturate at strong T
      end else begin
        wr_counter = head_rec.counter + 2'd1;
      end
    end else begin
      if (head_rec.counter == 2'd0) begin
        wr_counter = 2'd0;                      // Saturate at strong NT
      end else begin
        wr_counter = head_rec.counter - 2'd1;
      end
    end
  end

  assign bht_wen   = resolve_fire;                // Every slot is a branch
  assign btb_wen   = resolve_fire & actual_taken; // Learn taken targets only
  assign wr_pc     = head_rec.pc;
  assign wr_target = actual_target;

  ////////////////////////////////////////////////////////////////////////////
  // Mispredict and redirect
  ////////////////////////////////////////////////////////////////////////////
  assign dir_wrong  = head_rec.pred_taken != actual_taken;
  assign tgt_wrong  = head_rec.pred_taken & actual_taken &
                      (head_rec.pred_target != actual_target);
  assign mispredict = resolve_fire & (dir_wrong | tgt_wrong);

  assign redirect_pc = actual_taken ? actual_target : head_rec.pc + PC_STEP;

endmodule

// ==== verilog/bp_top.sv ====
/*
 * Top of the fetch-side branch prediction subsystem. Fetch and the
 * predictor produce one record per slot, the FIFO holds it until the
 * execute outcome arrives, and the resolver trains the tables.
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                enable,        // Fetch may issue
  input  logic                resolve_valid, // Execute has an outcome
  input  logic                actual_taken,
  input  logic [`BP_PC_W-1:0] actual_target,
  output logic                fetch_valid,   // Slot issued this cycle
  output logic [`BP_PC_W-1:0] fetch_pc,
  output logic                pred_taken,
  output logic [`BP_PC_W-1:0] pred_target,
  output logic                resolve_ready, // A record is waiting
  output logic                mispredict,
  output logic [`BP_PC_W-1:0] redirect_pc
);

  logic                issue;
  logic                resolve_fire;
  logic                full;
  logic                empty;
  logic                hit;
  logic [1:0]          counter;
  logic                bht_wen;
  logic                btb_wen;
  logic [`BP_PC_W-1:0] wr_pc;
  logic [1:0]          wr_counter;
  logic [`BP_PC_W-1:0] wr_target;
  bp_pkg::fetch_rec_t  push_rec;
  bp_pkg::fetch_rec_t  head_rec;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake glue
  ////////////////////////////////////////////////////////////////////////////
  assign issue         = enable & ~full & ~mispredict; // Hold slot on redirect
  assign fetch_valid   = issue;
  assign resolve_ready = ~empty;
  assign resolve_fire  = resolve_valid & ~empty;

  assign push_rec = '{pc: fetch_pc, counter: counter, hit: hit,
                      pred_taken: pred_taken, pred_target: pred_target};

  fetch_pc_gen u_fetch (
    .clk         (clk),
    .rst         (rst),
    .issue       (issue),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .redirect    (mispredict),
    .redirect_pc (redirect_pc),
    .fetch_pc    (fetch_pc)
  );

  branch_predictor u_pred (
    .clk (clk), .rst (rst), .rd_pc (fetch_pc),
    .bht_wen (bht_wen), .btb_wen (btb_wen), .wr_pc (wr_pc),
    .wr_counter (wr_counter), .wr_target (wr_target),
    .hit (hit), .counter (counter),
    .pred_taken (pred_taken), .pred_target (pred_target)
  );

  resolve_fifo u_fifo (
    .clk (clk), .rst (rst), .push (issue), .push_rec (push_rec),
    .pop (resolve_fire), .flush (mispredict), // Flush drops younger slots
    .head_rec (head_rec), .full (full), .empty (empty)
  );

  branch_resolver u_resolve (
    .resolve_fire (resolve_fire), .head_rec (head_rec),
    .actual_taken (actual_taken), .actual_target (actual_target),
    .bht_wen (bht_wen), .btb_wen (btb_wen), .wr_pc (wr_pc),
    .wr_counter (wr_counter), .wr_target (wr_target),
    .mispredict (mispredict), .redirect_pc (redirect_pc)
  );

endmodule

// ==== bench/bp_tb.sv ====
/*
 * Self-checking testbench for bp_top. Drives seeded random execute
 * outcomes, mirrors the BHT/BTB and the in-flight records, and checks
 * every fetch, prediction and resolve cycle against that model.
 */
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_tb;

  localparam int ENTRIES     = 1 << `BP_IDX_W;
  localparam int RESOLVES    = 2000;  // Resolves needed for a pass
  localparam int MAX_CYCLES  = 40000; // Main loop limit
  localparam int HOLD_PERIOD = 150;   // Cycles between back-pressure windows
  localparam int HOLD_LEN    = 8;     // Cycles with resolves withheld

  logic                clk;
  logic                rst;
  logic                enable;
  logic                resolve_valid;
  logic                actual_taken;
  logic [`BP_PC_W-1:0] actual_target;
  logic                fetch_valid;
  logic [`BP_PC_W-1:0] fetch_pc;
  logic                pred_taken;
  logic [`BP_PC_W-1:0] pred_target;
  logic                resolve_ready;
  logic                mispredict;
  logic [`BP_PC_W-1:0] redirect_pc;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////////////////////
  logic                 bht_v [ENTRIES]; // Mirror of BHT
  logic [`BP_TAG_W-1:0] bht_t [ENTRIES];
  logic [1:0]           bht_c [ENTRIES];
  logic                 btb_v [ENTRIES]; // Mirror of BTB
  logic [`BP_TAG_W-1:0] btb_t [ENTRIES];
  logic [`BP_PC_W-1:0]  btb_g [ENTRIES];
  logic [`BP_PC_W-1:0]  model_pc;        // Expected fetch_pc
  bp_pkg::fetch_rec_t   pend_q [$];      // Issued, not yet resolved

  bp_top dut (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .resolve_valid (resolve_valid),
    .actual_taken  (actual_taken),
    .actual_target (actual_target),
    .fetch_valid   (fetch_valid),
    .fetch_pc      (fetch_pc),
    .pred_taken    (pred_taken),
    .pred_target   (pred_target),
    .resolve_ready (resolve_ready),
    .mispredict    (mispredict),
    .redirect_pc   (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // Each PC leans one way, about 1 in 8 outcomes go against it
  function automatic logic outcome_taken(input logic [`BP_PC_W-1:0] pc);
    logic lean;
    lean = pc[1] ^ pc[4] ^ pc[6];
    if (($urandom % 8) == 0) begin
      return ~lean;
    end
    return lean;
  endfunction

  // Fixed target per PC; small set with shared indexes so tags collide
  function automatic logic [`BP_PC_W-1:0] branch_target(input logic [`BP_PC_W-1:0] pc);
    case (pc[3:1] ^ pc[6:4])
      3'd0:    return 16'h0000;
      3'd1:    return 16'h0010; // Same index as 0x0000, other tag
      3'd2:    return 16'h0022;
      3'd3:    return 16'h0106;
      3'd4:    return 16'h0048;
      3'd5:    return 16'h001a;
      3'd6:    return 16'h002c;
      default: return 16'h004e;
    endcase
  endfunction

  // Apply the counter and BTB update with the counter recorded at fetch
  task automatic train_model(input bp_pkg::fetch_rec_t rec, input logic taken,
                             input logic [`BP_PC_W-1:0] target);
    logic [`BP_IDX_W-1:0] idx;
    logic [1:0]           next_c;
    idx = rec.pc[`BP_IDX_W:1];
    if (!rec.hit) begin
      next_c = 2'd0;                                          // New owner
    end else if (taken) begin
      next_c = (rec.counter == 2'd3) ? 2'd3 : rec.counter + 2'd1;
    end else begin
      next_c = (rec.counter == 2'd0) ? 2'd0 : rec.counter - 2'd1;
    end
    bht_v[idx] = 1'b1;
    bht_t[idx] = rec.pc[`BP_PC_W-1:`BP_IDX_W+1];
    bht_c[idx] = next_c;
    if (taken) begin
      btb_v[idx] = 1'b1;
      btb_t[idx] = rec.pc[`BP_PC_W-1:`BP_IDX_W+1];
      btb_g[idx] = target;
    end
  endtask

  // Called at the rising edge; outcome follows the oldest pending slot
  task automatic drive_cycle(input logic hold);
    logic [`BP_PC_W-1:0] head_pc;
    logic                taken_now;
    logic [`BP_PC_W-1:0] noise;
    head_pc = 16'h0000;
    if (pend_q.size() != 0) begin
      head_pc = pend_q[0].pc;
    end
    taken_now = outcome_taken(head_pc);
    noise     = 16'($urandom) & 16'hfffe; // Don't-care target when not taken
    if (hold) begin
      enable        <= 1'b1;              // Fill the FIFO
      resolve_valid <= 1'b0;
    end else begin
      enable        <= ($urandom % 8) != 0;
      resolve_valid <= ($urandom % 4) != 0;
    end
    actual_taken  <= taken_now;
    actual_target <= taken_now ? branch_target(head_pc) : noise;
  endtask

  // Called at the falling edge: check outputs, then advance the model
  task automatic step_model(output logic fired);
    logic [`BP_IDX_W-1:0] idx;
    logic [`BP_TAG_W-1:0] tag;
    logic                 hit_m;
    logic [1:0]           cnt_m;
    logic                 btb_hit;
    logic                 ptk;
    logic [`BP_PC_W-1:0]  ptg;
    logic                 fire;
    logic                 mis;
    logic [`BP_PC_W-1:0]  rpc;
    logic                 issue_m;
    bp_pkg::fetch_rec_t   head;
    bp_pkg::fetch_rec_t   rec;
    idx     = model_pc[`BP_IDX_W:1];
    tag     = model_pc[`BP_PC_W-1:`BP_IDX_W+1];
    hit_m   = bht_v[idx] && (bht_t[idx] == tag);
    cnt_m   = bht_c[idx];                           // Old contents, before training
    btb_hit = btb_v[idx] && (btb_t[idx] == tag);
    ptk     = hit_m && cnt_m[1];                    // Taken only on tag hit
    ptg     = btb_hit ? btb_g[idx] : model_pc + 16'd2;
    check_value("fetch_pc", 32'(fetch_pc), 32'(model_pc));
    check_value("pred_taken", 32'(pred_taken), 32'(ptk));
    check_value("pred_target", 32'(pred_target), 32'(ptg));
    check_value("resolve_ready", 32'(resolve_ready), 32'(pend_q.size() != 0));
    fire = resolve_valid && (pend_q.size() != 0);
    mis  = 1'b0;
    rpc  = 16'h0000;
    if (fire) begin
      head = pend_q[0];
      mis  = (head.pred_taken != actual_taken) ||
             (head.pred_taken && actual_taken && (head.pred_target != actual_target));
      rpc  = actual_taken ? actual_target : head.pc + 16'd2;
      check_value("redirect_pc", 32'(redirect_pc), 32'(rpc));
    end
    check_value("mispredict", 32'(mispredict), 32'(mis));
    issue_m = enable && (pend_q.size() < `BP_FIFO_DEPTH) && !mis;
    check_value("fetch_valid", 32'(fetch_valid), 32'(issue_m));
    if (fire) begin                                 // Edge effects from here
      train_model(head, actual_taken, actual_target);
      void'(pend_q.pop_front());
    end
    if (mis) begin
      pend_q.delete();                              // Younger slots dropped
      model_pc = rpc;
    end else if (issue_m) begin
      rec = '{pc: model_pc, counter: cnt_m, hit: hit_m,
              pred_taken: ptk, pred_target: ptg};
      pend_q.push_back(rec);
      model_pc = ptk ? ptg : model_pc + 16'd2;
    end
    fired = fire;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int          cycle;
    int          resolves;
    logic        fired;
    void'($urandom(11));             // One seed for the whole run
    rst           <= 1'b1;
    enable        <= 1'b0;
    resolve_valid <= 1'b0;
    actual_taken  <= 1'b0;
    actual_target <= '0;
    for (int i = 0; i < ENTRIES; i++) begin
      bht_v[i] = 1'b0;
      bht_t[i] = '0;
      bht_c[i] = 2'd0;
      btb_v[i] = 1'b0;
      btb_t[i] = '0;
      btb_g[i] = '0;
    end
    model_pc = `BP_RESET_PC;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
    end
    rst <= 1'b0;
    @(negedge clk);                   // Post-reset state
    check_value("fetch_pc", 32'(fetch_pc), 32'(`BP_RESET_PC));
    check_value("fetch_valid", 32'(fetch_valid), 32'd0);
    check_value("resolve_ready", 32'(resolve_ready), 32'd0);
    check_value("mispredict", 32'(mispredict), 32'd0);
    check_value("pred_taken", 32'(pred_taken), 32'd0);
    check_value("pred_target", 32'(pred_target), 32'(`BP_RESET_PC + 16'd2));
    cycle    = 0;
    resolves = 0;
    while ((resolves < RESOLVES) && (cycle < MAX_CYCLES)) begin
      @(posedge clk);
      drive_cycle((cycle % HOLD_PERIOD) >= (HOLD_PERIOD - HOLD_LEN));
      @(negedge clk);
      step_model(fired);
      if (fired) begin
        resolves++;
      end
      if ((cycle % HOLD_PERIOD) == (HOLD_PERIOD - 1)) begin
        check_value("fetch_valid while full", 32'(fetch_valid), 32'd0); // Stalled
        check_value("resolve_ready while full", 32'(resolve_ready), 32'd1);
      end
      cycle++;
    end
    if (resolves < RESOLVES) begin
      $display("Timeout: only %0d of %0d resolves in %0d cycles", resolves, RESOLVES, cycle);
      $display("ERRORS FOUND");
      $fatal(1);
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+include
verilog/bp_pkg.sv
verilog/fetch_pc_gen.sv
verilog/branch_predictor.sv
verilog/resolve_fifo.sv
verilog/branch_resolver.sv
verilog/bp_top.sv
bench/bp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the branch prediction testbench with Verilator and run it.
# Exit status is nonzero when the build fails or the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f filelist.f --top-module bp_tb -Mdir obj_dir -o bp_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/bp_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
